// ==== logic/synth_pkg.sv ====
// --------------------------------------------------
// synth datapath widths and voice pitch types
// shared by the sequencers and the output stage
// --------------------------------------------------
package synth_pkg;

	// widths
	// --------------------------------------------------
	localparam int a_bits = 12;     // datapath width
	localparam int oct_bits = 3;    // octave field
	localparam int table_bits = 7;  // mantissa table entry

	// drum sweep field is one mantissa plus two octave bits
	localparam int drum_bits = a_bits - 1 + 2;

	// pitch types
	// --------------------------------------------------
	// table value on top, zero fill below
	typedef logic [a_bits-2:0] mantissa_t;

	typedef logic [oct_bits-1:0] oct_t;

	localparam oct_t oct_silent = '1;  // top octave code means no sound

	typedef struct packed {
		oct_t oct;
		mantissa_t mantissa;
	} voice_pitch_t;  // 14 bits

	typedef struct packed {
		voice_pitch_t chord;
		voice_pitch_t bass;
		voice_pitch_t drums;
	} voice_bundle_t;  // 42 bits

	// idle pitch, used after reset
	localparam voice_pitch_t pitch_silent = '{
		oct: oct_silent,
		mantissa: '0
	};

endpackage

// ==== logic/song_pkg.sv ====
// --------------------------------------------------
// song description types
// player control bits, track positions, note codes
// --------------------------------------------------
package song_pkg;

	// counter and position widths
	// --------------------------------------------------
	localparam int sample_count_bits = 23;
	localparam int track_pos_bits = 2;   // four chord slots per loop
	localparam int bass_pos_bits = 4;    // 16 bass steps per slot
	localparam int silence_log2 = 3;     // chord rests in first eighth of slot

	typedef logic [track_pos_bits-1:0] track_pos_t;
	typedef logic [bass_pos_bits-1:0] bass_pos_t;

	// note encoding
	// --------------------------------------------------
	// upper nibble octave, lower nibble index counted down from C
	typedef logic [7:0] note_t;

	localparam note_t note_silent = 8'hf0;
	localparam note_t note_c = 8'h10 + 8'd27;      // C root, plain
	localparam note_t note_c_mod = 8'h10 + 8'd15;  // C root, modulated
	localparam note_t bass_octave_step = 8'h20;    // bass root two codes lower

	// player control
	// --------------------------------------------------
	typedef struct packed {
		logic silence;        // mute chord and drums
		logic chords_on;      // full chord on last slot
		logic simple_bass;    // plain bass pattern
		logic raise_bass;     // bass one octave up
		logic modulate;       // shift the C root
		logic resolution;     // hold on slot 0
		logic preresolution;  // hold on slot 1
	} player_control_t;

	// position state handed to the sequencers
	typedef struct packed {
		track_pos_t track_pos;   // after resolution overrides
		track_pos_t track_pos0;  // raw counter slot
		bass_pos_t bass_pos;
		logic silence_chord;
	} track_state_t;

endpackage

// ==== logic/track_position.sv ====
// --------------------------------------------------
// track position decode
// slices the sample counter into chord and bass steps
// --------------------------------------------------
`timescale 1ns/10ps

module track_position #(
	parameter int track_log2_wait = 19  // log2 of samples per chord slot
) (
	input logic [song_pkg::sample_count_bits-1:0] sample_counter,
	input song_pkg::player_control_t control,
	output song_pkg::track_state_t state,
	output logic raise_drum
);
	import song_pkg::*;

	// bass steps subdivide one chord slot
	localparam int bass_log2_wait = track_log2_wait - bass_pos_bits;

	track_pos_t track_pos0;
	logic second_loop;
	logic slot_start;

	// raw counter fields
	// --------------------------------------------------
	assign track_pos0 = sample_counter[track_log2_wait+track_pos_bits-1 -: track_pos_bits];
	assign second_loop = sample_counter[track_log2_wait+track_pos_bits];  // loop bit above slots
	assign slot_start = (sample_counter[track_log2_wait-1 -: silence_log2] == '0);

	always_comb begin
		state.track_pos0 = track_pos0;
		state.bass_pos = sample_counter[bass_log2_wait+bass_pos_bits-1 -: bass_pos_bits];

		// resolution overrides, preresolution wins
		if (control.preresolution) begin
			state.track_pos = 2'd1;
		end else if (control.resolution) begin
			state.track_pos = 2'd0;
		end else begin
			state.track_pos = track_pos0;
		end

		// short rest at slot start, only slot 0 under resolution
		state.silence_chord = slot_start && (!control.resolution || track_pos0 == '0);
	end

	// drum goes up in last bar of second loop
	assign raise_drum = (track_pos0 == 2'd3) && second_loop;

endmodule

// ==== logic/chord_sequencer.sv ====
// --------------------------------------------------
// chord root sequencer
// --------------------------------------------------
`timescale 1ns/10ps

module chord_sequencer (
	input song_pkg::track_state_t state,
	input song_pkg::player_control_t control,
	output song_pkg::note_t note
);
	import song_pkg::*;

	note_t c_note;  // root of slot 0

	assign c_note = control.modulate ? note_c_mod : note_c;

	// one root per slot
	// --------------------------------------------------
	always_comb begin
		case (state.track_pos)
			2'd0: note = c_note;
			2'd1: note = 8'h26;
			2'd2: note = 8'h24;
			default: begin
				// last slot darker without full chord
				note = control.chords_on ? 8'h20 : 8'h27;
			end
		endcase

		// rest overrides everything
		if (state.silence_chord || control.silence) begin
			note = note_silent;
		end
	end

endmodule

// ==== logic/bass_sequencer.sv ====
// --------------------------------------------------
// bass sequencer
// two notes per slot, placed by a 16 step pattern
// --------------------------------------------------
`timescale 1ns/10ps

module bass_sequencer (
	input song_pkg::track_state_t state,
	input song_pkg::player_control_t control,
	output song_pkg::note_t note
);
	import song_pkg::*;

	note_t c_note;
	note_t first_note;   // root of the slot
	note_t second_note;  // answering note

	assign c_note = control.modulate ? note_c_mod : note_c;

	// note pair per slot
	// --------------------------------------------------
	always_comb begin
		case (state.track_pos)
			2'd0: begin
				first_note = c_note + bass_octave_step;
				second_note = 8'h36;
			end
			2'd1: begin
				first_note = 8'h31;
				second_note = 8'h36;
			end
			2'd2: begin
				first_note = c_note + bass_octave_step;
				second_note = 8'h34;
			end
			default: begin
				first_note = 8'h34;
				second_note = 8'h37;
			end
		endcase
	end

	// step pattern
	// --------------------------------------------------
	always_comb begin
		note = note_silent;  // gaps between hits
		if (control.simple_bass) begin
			case (state.bass_pos)
				4'd0, 4'd2, 4'd4, 4'd8, 4'd12, 4'd14: note = first_note;
				4'd1, 4'd6, 4'd10, 4'd13: note = second_note;
				default: note = note_silent;
			endcase
		end else if (state.track_pos0 != 2'd3) begin
			case (state.bass_pos)
				4'd0, 4'd2, 4'd4, 4'd5, 4'd8, 4'd12, 4'd13: note = first_note;
				4'd1, 4'd6, 4'd10, 4'd14: note = second_note;
				default: note = note_silent;
			endcase
		end else begin
			// last raw slot, syncopated fill
			case (state.bass_pos)
				4'd0, 4'd4, 4'd8, 4'd9, 4'd12: note = first_note;
				4'd2, 4'd6, 4'd10, 4'd14: note = second_note;
				default: note = note_silent;
			endcase
		end
	end

endmodule

// ==== logic/pitch_output.sv ====
// --------------------------------------------------
// pitch output stage
// note to mantissa/octave, drum sweep, output register
// --------------------------------------------------
`timescale 1ns/10ps

module pitch_output #(
	parameter int track_log2_wait = 19
) (
	input logic clk,
	input logic reset,
	input logic [song_pkg::sample_count_bits-1:0] sample_counter,
	input song_pkg::player_control_t control,
	input song_pkg::note_t chord_note,
	input song_pkg::note_t bass_note,
	input logic raise_drum_next,
	output synth_pkg::voice_bundle_t voices,
	output logic raise_drum
);
	import synth_pkg::*;
	import song_pkg::*;

	// one octave of mantissas counted down from C
	function automatic mantissa_t lookup_mantissa(input logic [3:0] index);
		logic [table_bits:0] value;  // top bit always set and dropped
		case (index)
			4'd0: value = 8'd246;
			4'd1: value = 8'd232;
			4'd2: value = 8'd219;
			4'd3: value = 8'd207;
			4'd4: value = 8'd195;
			4'd5: value = 8'd184;
			4'd6: value = 8'd174;
			4'd7: value = 8'd164;
			4'd8: value = 8'd155;
			4'd9: value = 8'd146;
			4'd10: value = 8'd138;
			4'd11: value = 8'd130;
			default: value = '0;  // unused codes
		endcase
		return {value[table_bits-1:0], {(a_bits-1-table_bits){1'b0}}};
	endfunction

	logic [drum_bits-1:0] drum_freq;  // sweep taken from counter
	oct_t bass_oct0;
	voice_bundle_t voices_next;

	assign drum_freq = sample_counter[track_log2_wait-3 -: drum_bits];
	assign bass_oct0 = bass_note[oct_bits+3:4];

	always_comb begin
		voices_next.chord.oct = chord_note[oct_bits+3:4];
		voices_next.chord.mantissa = lookup_mantissa(chord_note[3:0]);

		voices_next.bass.oct = bass_oct0;
		if (control.raise_bass && bass_oct0 != oct_silent) begin
			voices_next.bass.oct = bass_oct0 - 1'b1;  // lower code is higher pitch
		end
		voices_next.bass.mantissa = lookup_mantissa(bass_note[3:0]);

		voices_next.drums.oct = oct_t'(drum_freq[drum_bits-1 -: 2]);
		voices_next.drums.mantissa = drum_freq[a_bits-2:0];
		if (control.silence || control.resolution) begin
			voices_next.drums.oct = oct_silent;  // drums mute
		end
	end

	// output register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			voices <= '{chord: pitch_silent, bass: pitch_silent, drums: pitch_silent};
			raise_drum <= 1'b0;
		end else begin
			voices <= voices_next;
			raise_drum <= raise_drum_next;
		end
	end

endmodule

// ==== logic/note_player.sv ====
// --------------------------------------------------
// note player top
// sample counter and controls in, voice pitches out
// --------------------------------------------------
`timescale 1ns/10ps

module note_player #(
	parameter int track_log2_wait = 19  // samples per chord slot, log2
) (
	input logic clk,
	input logic reset,
	input logic [song_pkg::sample_count_bits-1:0] sample_counter,
	input song_pkg::player_control_t control,
	output synth_pkg::voice_bundle_t voices,
	output logic raise_drum
);
	import song_pkg::*;

	track_state_t state;
	note_t chord_note;
	note_t bass_note;
	logic raise_drum_next;  // before output register

	// sequencing, all combinational
	// --------------------------------------------------
	track_position #(.track_log2_wait(track_log2_wait)) i_track_position (
		.sample_counter(sample_counter),
		.control(control),
		.state(state),
		.raise_drum(raise_drum_next)
	);

	chord_sequencer i_chord_sequencer (.state(state), .control(control), .note(chord_note));

	bass_sequencer i_bass_sequencer (.state(state), .control(control), .note(bass_note));

	// lookup and register, one cycle
	pitch_output #(.track_log2_wait(track_log2_wait)) i_pitch_output (
		.clk(clk),
		.reset(reset),
		.sample_counter(sample_counter),
		.control(control),
		.chord_note(chord_note),
		.bass_note(bass_note),
		.raise_drum_next(raise_drum_next),
		.voices(voices),
		.raise_drum(raise_drum)
	);

endmodule

// ==== include/note_model.svh ====
// --------------------------------------------------
// note player reference model
// expected voice pitches from counter and controls
// --------------------------------------------------
`ifndef NOTE_MODEL_SVH
`define NOTE_MODEL_SVH

localparam int model_log2_wait = 19;  // matches DUT default

// table value placed above the zero fill
function automatic synth_pkg::mantissa_t model_mantissa(input logic [3:0] index);
	int values[12] = '{246, 232, 219, 207, 195, 184, 174, 164, 155, 146, 138, 130};
	if (index > 4'd11) begin
		return '0;
	end
	return synth_pkg::mantissa_t'(values[index] << 4);
endfunction

// note code to pitch, optional bass raise
function automatic synth_pkg::voice_pitch_t model_pitch(input song_pkg::note_t note,
		input logic raise);
	synth_pkg::voice_pitch_t pitch;
	pitch.oct = note[6:4];
	if (raise && pitch.oct != 3'd7) begin
		pitch.oct = pitch.oct - 3'd1;
	end
	pitch.mantissa = model_mantissa(note[3:0]);
	return pitch;
endfunction

function automatic synth_pkg::voice_bundle_t model_voices(
		input logic [22:0] counter,
		input song_pkg::player_control_t control,
		output logic raise_drum);
	synth_pkg::voice_bundle_t expected;
	logic [1:0] pos0;
	logic [1:0] pos;
	logic [3:0] step;
	logic [15:0] first_mask;
	logic [15:0] second_mask;
	logic [7:0] root;
	logic [7:0] chord;
	logic [7:0] bass;
	logic [12:0] sweep;

	pos0 = counter[model_log2_wait+1 -: 2];
	pos = control.preresolution ? 2'd1 : (control.resolution ? 2'd0 : pos0);
	step = counter[model_log2_wait-1 -: 4];
	root = control.modulate ? 8'h1f : 8'h2b;
	raise_drum = (pos0 == 2'd3) && counter[model_log2_wait+2];

	// chord root, rest at slot start
	chord = (pos == 2'd0) ? root : (pos == 2'd1) ? 8'h26 : (pos == 2'd2) ? 8'h24 :
		(control.chords_on ? 8'h20 : 8'h27);
	if (control.silence || ((counter[model_log2_wait-1 -: 3] == 3'd0) &&
			(!control.resolution || pos0 == 2'd0))) begin
		chord = 8'hf0;
	end

	// bass hits as step bit masks
	first_mask = control.simple_bass ? 16'h5115 : (pos0 != 2'd3) ? 16'h3135 : 16'h1311;
	second_mask = control.simple_bass ? 16'h2442 : (pos0 != 2'd3) ? 16'h4442 : 16'h4444;
	bass = 8'hf0;
	if (first_mask[step]) begin
		bass = (pos == 2'd1) ? 8'h31 : (pos == 2'd3) ? 8'h34 : root + 8'h20;
	end else if (second_mask[step]) begin
		bass = (pos == 2'd2) ? 8'h34 : (pos == 2'd3) ? 8'h37 : 8'h36;
	end

	// drum sweep straight from counter bits
	sweep = counter[model_log2_wait-3 -: 13];
	expected.chord = model_pitch(chord, 1'b0);
	expected.bass = model_pitch(bass, control.raise_bass);
	expected.drums.oct = (control.silence || control.resolution) ? 3'd7 : {1'b0, sweep[12:11]};
	expected.drums.mantissa = sweep[10:0];
	return expected;
endfunction

`endif

// ==== sim/tb_note_player.sv ====
// --------------------------------------------------
// note player testbench
// swept and random counters checked against the model
// --------------------------------------------------
`timescale 1ns/10ps

module tb_note_player;
	import synth_pkg::*;
	import song_pkg::*;

	`include "note_model.svh"

	localparam int clk_period = 100;
	localparam int sweep_cycles = 4 * 4 * 16;  // combos x slots x steps
	localparam int random_cycles = 64;
	localparam int stream_cycles = 200;
	localparam int total_cycles = 4 + sweep_cycles + 3 * random_cycles + stream_cycles;

	typedef struct packed {
		logic [31:0] due;        // cycle at which the output is valid
		voice_bundle_t voices;
		logic raise_drum;
	} expectation_t;

	logic clk;
	logic reset;
	logic [sample_count_bits-1:0] sample_counter;
	player_control_t control;
	voice_bundle_t voices;
	logic raise_drum;

	expectation_t pending[$];  // in flight, oldest first
	int cycle_count = 0;
	int check_count = 0;
	int error_count = 0;
	int test_checks;
	int test_errors;
	int test_number = 0;

	note_player i_dut (
		.clk(clk),
		.reset(reset),
		.sample_counter(sample_counter),
		.control(control),
		.voices(voices),
		.raise_drum(raise_drum)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	always @(posedge clk) cycle_count <= cycle_count + 1;

	// compare tasks
	// --------------------------------------------------
	task automatic check_voice(input string name, input voice_pitch_t got, input voice_pitch_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("CHECK FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("CHECK FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	function automatic logic [sample_count_bits-1:0] random_counter();
		logic [31:0] r;
		r = $urandom;
		return r[sample_count_bits-1:0];
	endfunction

	function automatic player_control_t random_control();
		logic [31:0] r;
		r = $urandom;
		return r[6:0];
	endfunction

	// stimulus helpers
	// --------------------------------------------------
	// new inputs just after the edge, expectation due one edge later
	task automatic drive(input logic [sample_count_bits-1:0] counter, input player_control_t ctrl);
		expectation_t entry;
		logic raise;
		@(posedge clk);
		#1;
		sample_counter = counter;
		control = ctrl;
		entry.due = cycle_count + 1;
		entry.voices = model_voices(counter, ctrl, raise);
		entry.raise_drum = raise;
		pending.push_back(entry);
	endtask

	task automatic start_test();
		test_number++;
		test_checks = check_count;
		test_errors = error_count;
	endtask

	// waits for the compare side to drain
	task automatic report_test(input string name);
		while (pending.size() != 0) @(negedge clk);
		$display("test %0d %s: %0d checks, %0d errors", test_number, name,
			check_count - test_checks, error_count - test_errors);
	endtask

	// compare process, outputs sampled mid cycle
	initial begin
		expectation_t entry;
		forever begin
			@(negedge clk);
			while (pending.size() > 0 && pending[0].due == cycle_count) begin
				entry = pending.pop_front();
				check_voice("voices.chord", voices.chord, entry.voices.chord);
				check_voice("voices.bass", voices.bass, entry.voices.bass);
				check_voice("voices.drums", voices.drums, entry.voices.drums);
				check_flag("raise_drum", raise_drum, entry.raise_drum);
			end
		end
	end

	// watchdog
	initial begin
		#((total_cycles + 100) * clk_period);
		$display("watchdog expired after %0d cycles, outputs never drained", total_cycles + 100);
		$display("FAIL: see errors above");
		$finish;
	end

	// test sequence
	// --------------------------------------------------
	initial begin
		int seed;
		logic [sample_count_bits-1:0] counter;
		player_control_t ctrl;
		voice_pitch_t silent;

		seed = $urandom(29);
		reset = 1'b1;
		sample_counter = 23'h3c_8000;  // last slot of second loop, drum would rise
		control = '0;
		silent.oct = 3'd7;
		silent.mantissa = '0;

		// 1: reset holds every voice silent
		start_test();
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_voice("voices.chord", voices.chord, silent);
		check_voice("voices.bass", voices.bass, silent);
		check_voice("voices.drums", voices.drums, silent);
		check_flag("raise_drum", raise_drum, 1'b0);
		report_test("reset");
		@(posedge clk);
		#1 reset = 1'b0;

		// 2: every slot and step, simple_bass x chords_on
		start_test();
		for (int combo = 0; combo < 4; combo++) begin
			for (int pos = 0; pos < 4; pos++) begin
				for (int step = 0; step < 16; step++) begin
					ctrl = '0;
					ctrl.simple_bass = combo[0];
					ctrl.chords_on = combo[1];
					counter = random_counter();
					counter[model_log2_wait+1 -: 2] = pos[1:0];
					counter[model_log2_wait-1 -: 4] = step[3:0];
					drive(counter, ctrl);
				end
			end
		end
		report_test("chord and bass sweep");

		// 3: modulated root, raised bass
		start_test();
		repeat (random_cycles) begin
			ctrl = '0;
			ctrl.modulate = $urandom_range(1);
			ctrl.raise_bass = $urandom_range(1);
			ctrl.simple_bass = $urandom_range(1);
			drive(random_counter(), ctrl);
		end
		report_test("modulate and raise_bass");

		// 4: drum sweep, muted by silence or resolution
		start_test();
		repeat (random_cycles) begin
			ctrl = '0;
			ctrl.silence = $urandom_range(1);
			ctrl.resolution = $urandom_range(1);
			drive(random_counter(), ctrl);
		end
		report_test("drum sweep");

		// 5: forced slots, chord rest rule, drum raise
		start_test();
		repeat (random_cycles) begin
			ctrl = random_control();
			ctrl.silence = 1'b0;
			drive(random_counter(), ctrl);
		end
		report_test("resolution");

		// 6: back to back, anything goes
		start_test();
		repeat (stream_cycles) drive(random_counter(), random_control());
		report_test("random stream");

		$display("tests done: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+include
logic/synth_pkg.sv
logic/song_pkg.sv
logic/track_position.sv
logic/chord_sequencer.sv
logic/bass_sequencer.sv
logic/pitch_output.sv
logic/note_player.sv
sim/tb_note_player.sv

// ==== Bender.yml ====
package:
  name: note_player

sources:
  - logic/synth_pkg.sv
  - logic/song_pkg.sv
  - logic/track_position.sv
  - logic/chord_sequencer.sv
  - logic/bass_sequencer.sv
  - logic/pitch_output.sv
  - logic/note_player.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_note_player.sv
